//--- tb.f
source/audio_pkg.sv
source/digimax_pkg.sv
source/digimax_dac.sv
source/fm_compressor.sv
source/stereo_mixer.sv
source/audio_top.sv
tests/audio_assertions.sv
tests/audio_tb.sv

//--- tests/audio_tb.sv
// Random-stimulus testbench for the audio back end, checked against a behavioral model
`timescale 1ns/10ps
`default_nettype none

module audio_tb;

	localparam int COMP_F      = audio_pkg::COMP_F_DEF;
	localparam int COMP_A      = audio_pkg::COMP_A_DEF;
	localparam int ACK_TIMEOUT = 20;

	logic                                  clk_sys = 1'b0;
	logic                                  RESET;
	logic                                  dmx_en_i;
	logic                                  wr_req_i;
	logic [digimax_pkg::ADDR_W-1:0]        wr_addr_i;
	logic [digimax_pkg::DAC_W-1:0]         wr_data_i;
	logic                                  wr_ack_o;
	logic signed [audio_pkg::SAMPLE_W-1:0] fm_sample_i;
	logic signed [audio_pkg::SID_W-1:0]    sid_l_i;
	logic signed [audio_pkg::SID_W-1:0]    sid_r_i;
	logic                                  cass_snd_i;
	logic [audio_pkg::SAMPLE_W-1:0]        audio_l_o;
	logic [audio_pkg::SAMPLE_W-1:0]        audio_r_o;

	integer     seed = 41214;
	int         ch_m [digimax_pkg::NUM_CH];
	logic [3:0] act_m;
	int         test_checks;
	int         test_errs;
	int         total_checks;
	int         total_errs;
	int         num_tests;

	audio_top dut0 (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dmx_en_i    (dmx_en_i),
		.wr_req_i    (wr_req_i),
		.wr_addr_i   (wr_addr_i),
		.wr_data_i   (wr_data_i),
		.wr_ack_o    (wr_ack_o),
		.fm_sample_i (fm_sample_i),
		.sid_l_i     (sid_l_i),
		.sid_r_i     (sid_r_i),
		.cass_snd_i  (cass_snd_i),
		.audio_l_o   (audio_l_o),
		.audio_r_o   (audio_r_o)
	);

	always #10 clk_sys = ~clk_sys;

	// Watchdog for a stuck run
	initial begin
		#1_000_000;
		$display("simulation ran past its time limit");
		$display("STATUS: FAIL");
		$finish;
	end

	// ==================================================
	// Reference model
	// ==================================================

	function automatic int compress_model(input int s);
		int att;
		int mag;
		int knee;
		int res;
		knee = ((32767 * (COMP_F - 1)) / ((COMP_F * COMP_A) - 1)) + 1;
		att  = s - (s >>> 3);
		mag  = (att < 0) ? -att : att;
		if (mag < knee) begin
			res = mag * COMP_A;
		end else begin
			res = ((mag - knee) / COMP_F) + (knee * COMP_A);
		end
		return (att < 0) ? -res : res;
	endfunction

	function automatic int dac_side_model(input logic left);
		if (act_m < 2) begin
			return 2 * ch_m[0];
		end else if (act_m == 2) begin
			return left ? 2 * ch_m[1] : 2 * ch_m[0];
		end
		return left ? ch_m[1] + ch_m[2] : ch_m[0] + ch_m[3];
	endfunction

	// 17-bit sum, clipped when the two top bits disagree
	function automatic logic [15:0] mix_model(input int fm_c, input int sid, input int dac,
			input logic cass);
		int          sum;
		logic [16:0] s17;
		sum = fm_c + (sid >>> 2) + (dac << digimax_pkg::DAC_SHIFT)
			+ (int'(cass) << audio_pkg::CASS_SHIFT);
		s17 = 17'(sum);
		if (s17[16] != s17[15]) begin
			return s17[16] ? 16'h8000 : 16'h7FFF;
		end
		return s17[15:0];
	endfunction

	// ==================================================
	// Helpers
	// ==================================================

	task automatic check_out(input string name, input logic [15:0] exp, input logic [15:0] act);
		test_checks++;
		if (act !== exp) begin
			test_errs++;
			$display("error %s expected 0x%04h actual 0x%04h", name, exp, act);
		end
	endtask

	// Compare both sides against the inputs currently held
	task automatic check_held(input string name);
		check_out(name, mix_model(compress_model(fm_sample_i), sid_l_i, dac_side_model(1'b1),
			cass_snd_i), audio_l_o);
		check_out(name, mix_model(compress_model(fm_sample_i), sid_r_i, dac_side_model(1'b0),
			cass_snd_i), audio_r_o);
	endtask

	task automatic end_test(input string name);
		num_tests++;
		total_checks += test_checks;
		total_errs   += test_errs;
		$display("test %s finished: %0d checks, %0d errors", name, test_checks, test_errs);
		test_checks = 0;
		test_errs   = 0;
	endtask

	task automatic settle(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic set_enable(input logic en);
		@(negedge clk_sys);
		dmx_en_i = en;
		if (!en) begin
			act_m = '0;
			for (int i = 0; i < digimax_pkg::NUM_CH; i++) begin
				ch_m[i] = 0;
			end
		end
	endtask

	// Four-phase write, then the model takes the same write
	task automatic write_dac(input logic [2:0] addr, input logic [7:0] data);
		int wait_n;
		@(negedge clk_sys);
		wr_addr_i = addr;
		wr_data_i = data;
		wr_req_i  = 1'b1;
		wait_n    = 0;
		while (!wr_ack_o && wait_n < ACK_TIMEOUT) begin
			@(negedge clk_sys);
			wait_n++;
		end
		if (!wr_ack_o) begin
			test_errs++;
			$display("no ack arrived for the write to address %0d", addr);
		end
		wr_req_i = 1'b0;
		wait_n   = 0;
		while (wr_ack_o && wait_n < ACK_TIMEOUT) begin
			@(negedge clk_sys);
			wait_n++;
		end
		if (wr_ack_o) begin
			test_errs++;
			$display("ack stayed high after req was dropped, address %0d", addr);
		end
		if (dmx_en_i && !addr[2]) begin
			ch_m[addr[1:0]] = data;
			if (data != 0) begin
				act_m[addr[1:0]] = 1'b1;
			end
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		logic [15:0] exp_q [$];
		int          fm_dir [$];
		logic [15:0] before_l;
		logic [15:0] before_r;
		RESET       = 1'b1;
		dmx_en_i    = 1'b0;
		// Request held through reset, which must go unanswered
		wr_req_i    = 1'b1;
		wr_addr_i   = '0;
		wr_data_i   = '0;
		fm_sample_i = '0;
		sid_l_i     = '0;
		sid_r_i     = '0;
		cass_snd_i  = 1'b0;
		act_m       = '0;
		for (int i = 0; i < digimax_pkg::NUM_CH; i++) begin
			ch_m[i] = 0;
		end
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET    = 1'b0;
		wr_req_i = 1'b0;
		check_out("reset_state", 16'h0000, {15'b0, wr_ack_o});
		check_out("reset_state", 16'h0000, audio_l_o);
		check_out("reset_state", 16'h0000, audio_r_o);
		end_test("reset_state");
		settle(2);

		// Streamed FM samples, four in flight
		set_enable(1'b1);
		fm_dir = '{0, 1, -1, 16049, 16050, -16049, -16050, 32767, -32768};
		repeat (4) exp_q.push_back(16'h0000);
		for (int i = 0; i < 49; i++) begin
			@(negedge clk_sys);
			before_l = exp_q.pop_front();
			check_out("fm_compression", before_l, audio_l_o);
			check_out("fm_compression", before_l, audio_r_o);
			fm_sample_i = (i < fm_dir.size()) ? 16'(fm_dir[i]) :
				((i < 45) ? 16'($random(seed)) : 16'h0000);
			exp_q.push_back(mix_model(compress_model(fm_sample_i), 0, 0, 1'b0));
		end
		end_test("fm_compression");

		for (int c = 0; c < digimax_pkg::NUM_CH; c++) begin
			write_dac(3'(c), 8'($random(seed)) | 8'h01);
			settle(4);
			check_held("channel_guess");
		end
		// Stereo pair with only channel 1 in use
		set_enable(1'b0);
		set_enable(1'b1);
		write_dac(3'd1, 8'($random(seed)) | 8'h01);
		settle(4);
		check_held("channel_guess");
		end_test("channel_guess");

		before_l = audio_l_o;
		before_r = audio_r_o;
		write_dac(3'b100 | 3'($random(seed) & 3), 8'hC3);
		settle(4);
		check_out("out_of_range", before_l, audio_l_o);
		check_out("out_of_range", before_r, audio_r_o);
		check_held("out_of_range");
		set_enable(1'b0);
		settle(4);
		check_held("out_of_range");
		write_dac(3'd0, 8'hA5);
		set_enable(1'b1);
		settle(4);
		check_held("out_of_range");
		end_test("out_of_range");

		for (int i = 0; i < 20; i++) begin
			write_dac({1'b0, 2'($random(seed))}, 8'($random(seed)));
			@(negedge clk_sys);
			fm_sample_i = 16'($random(seed));
			sid_l_i     = 18'($random(seed));
			sid_r_i     = 18'($random(seed));
			cass_snd_i  = 1'($random(seed));
			settle(6);
			check_held("full_mix");
		end
		// Wide left DAC pair against a narrow right pair drives both clip values
		set_enable(1'b0);
		set_enable(1'b1);
		write_dac(3'd1, 8'hFF);
		write_dac(3'd2, 8'hFF);
		write_dac(3'd0, 8'h01);
		write_dac(3'd3, 8'h01);
		@(negedge clk_sys);
		fm_sample_i = -16'sd32768;
		sid_l_i     = 18'sh1FFFF;
		sid_r_i     = 18'sh20000;
		cass_snd_i  = 1'b0;
		settle(6);
		check_held("full_mix");
		check_out("full_mix", 16'h7FFF, audio_l_o);
		check_out("full_mix", 16'h8000, audio_r_o);
		end_test("full_mix");

		// Failures flagged by the bound handshake checker
		total_errs += dut0.dac0.chk0.fail_cnt;

		$display("summary: %0d tests, %0d checks, %0d errors", num_tests, total_checks,
			total_errs);
		if (total_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/audio_assertions.sv
// Handshake, reset and enable checks bound into the DigiMax DAC bank
`timescale 1ns/10ps
`default_nettype none

module audio_assertions (
	input wire                           clk_sys,
	input wire                           RESET,
	input wire                           dmx_en_i,
	input wire                           wr_req_i,
	input wire                           wr_ack_o,
	input wire [digimax_pkg::SUM_W-1:0]  dac_l_o,
	input wire [digimax_pkg::SUM_W-1:0]  dac_r_o
);

	// Number of assertion failures so far
	int fail_cnt = 0;

	// Ack only answers a pending request
	ack_rise_on_req: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(wr_ack_o) |-> $past(wr_req_i))
		else begin
			fail_cnt++;
			$error("ack rose without a request");
		end

	ack_fall_after_req: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(wr_ack_o) |-> !$past(wr_req_i))
		else begin
			fail_cnt++;
			$error("ack fell while the request was still high");
		end

	ack_low_in_reset: assert property (@(posedge clk_sys)
		RESET |=> !wr_ack_o)
		else begin
			fail_cnt++;
			$error("ack high during reset");
		end

	// Disabled bank is silent one cycle later
	silent_when_off: assert property (@(posedge clk_sys) disable iff (RESET)
		!dmx_en_i |=> (dac_l_o == '0 && dac_r_o == '0))
		else begin
			fail_cnt++;
			$error("DAC sums nonzero after enable went low");
		end

endmodule

bind digimax_dac audio_assertions chk0 (
	.clk_sys  (clk_sys),
	.RESET    (RESET),
	.dmx_en_i (dmx_en_i),
	.wr_req_i (wr_req_i),
	.wr_ack_o (wr_ack_o),
	.dac_l_o  (dac_l_o),
	.dac_r_o  (dac_r_o)
);

`default_nettype wire

//--- source/audio_top.sv
// Audio back end joining the DigiMax bank and FM compressor into the stereo mixer
`timescale 1ns/10ps
`default_nettype none

module audio_top #(
	parameter int COMP_F = audio_pkg::COMP_F_DEF,
	parameter int COMP_A = audio_pkg::COMP_A_DEF
) (
	input  wire                                  clk_sys,
	input  wire                                  RESET,
	input  wire                                  dmx_en_i,
	input  wire                                  wr_req_i,
	input  wire [digimax_pkg::ADDR_W-1:0]        wr_addr_i,
	input  wire [digimax_pkg::DAC_W-1:0]         wr_data_i,
	output logic                                 wr_ack_o,
	input  wire signed [audio_pkg::SAMPLE_W-1:0] fm_sample_i,
	input  wire signed [audio_pkg::SID_W-1:0]    sid_l_i,
	input  wire signed [audio_pkg::SID_W-1:0]    sid_r_i,
	input  wire                                  cass_snd_i,
	output logic [audio_pkg::SAMPLE_W-1:0]       audio_l_o,
	output logic [audio_pkg::SAMPLE_W-1:0]       audio_r_o
);

	logic [digimax_pkg::SUM_W-1:0]       dac_l;
	logic [digimax_pkg::SUM_W-1:0]       dac_r;
	logic signed [audio_pkg::SAMPLE_W-1:0] fm_comp;

	// ==================================================
	// Sources
	// ==================================================

	digimax_dac dac0 (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dmx_en_i  (dmx_en_i),
		.wr_req_i  (wr_req_i),
		.wr_addr_i (wr_addr_i),
		.wr_data_i (wr_data_i),
		.wr_ack_o  (wr_ack_o),
		.dac_l_o   (dac_l),
		.dac_r_o   (dac_r)
	);

	fm_compressor #(
		.COMP_F (COMP_F),
		.COMP_A (COMP_A)
	) comp0 (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.fm_sample_i (fm_sample_i),
		.fm_comp_o   (fm_comp)
	);

	// Final mix, two cycles after the sources
	stereo_mixer mix0 (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.fm_comp_i  (fm_comp),
		.sid_l_i    (sid_l_i),
		.sid_r_i    (sid_r_i),
		.dac_l_i    (dac_l),
		.dac_r_i    (dac_r),
		.cass_snd_i (cass_snd_i),
		.audio_l_o  (audio_l_o),
		.audio_r_o  (audio_r_o)
	);

endmodule

`default_nettype wire

//--- source/stereo_mixer.sv
// Stereo mixer summing FM, SID, DigiMax and cassette per side with 16-bit saturation
`timescale 1ns/10ps
`default_nettype none

module stereo_mixer (
	input  wire                                  clk_sys,
	input  wire                                  RESET,
	input  wire signed [audio_pkg::SAMPLE_W-1:0] fm_comp_i,
	input  wire signed [audio_pkg::SID_W-1:0]    sid_l_i,
	input  wire signed [audio_pkg::SID_W-1:0]    sid_r_i,
	input  wire [digimax_pkg::SUM_W-1:0]         dac_l_i,
	input  wire [digimax_pkg::SUM_W-1:0]         dac_r_i,
	input  wire                                  cass_snd_i,
	output logic [audio_pkg::SAMPLE_W-1:0]       audio_l_o,
	output logic [audio_pkg::SAMPLE_W-1:0]       audio_r_o
);

	localparam int SW = audio_pkg::SAMPLE_W;
	// One guard bit to catch overflow
	localparam int MW = SW + 1;

	logic [MW-1:0] common_term;
	logic [MW-1:0] sum_l_q;
	logic [MW-1:0] sum_r_q;

	// Per-side part of the sum, SID quartered and DAC moved up
	function automatic logic [MW-1:0] side_mix(
		input logic [MW-1:0]                   base,
		input logic signed [audio_pkg::SID_W-1:0] sid,
		input logic [digimax_pkg::SUM_W-1:0]   dac
	);
		logic [MW-1:0] sid_term;
		logic [MW-1:0] dac_term;
		sid_term = MW'(sid >>> 2);
		dac_term = MW'(dac) << digimax_pkg::DAC_SHIFT;
		side_mix = base + sid_term + dac_term;
	endfunction

	// Clamp when the guard bit disagrees with the sign
	function automatic logic [SW-1:0] saturate(input logic [MW-1:0] s);
		if (s[MW-1] != s[MW-2]) begin
			saturate = {s[MW-1], {(SW - 1){s[MW-2]}}};
		end else begin
			saturate = s[SW-1:0];
		end
	endfunction

	// FM and the click are shared by both sides
	assign common_term = MW'(fm_comp_i) + (MW'(cass_snd_i) << audio_pkg::CASS_SHIFT);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sum_l_q   <= '0;
			sum_r_q   <= '0;
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			sum_l_q   <= side_mix(common_term, sid_l_i, dac_l_i);
			sum_r_q   <= side_mix(common_term, sid_r_i, dac_r_i);
			audio_l_o <= saturate(sum_l_q);
			audio_r_o <= saturate(sum_r_q);
		end
	end

endmodule

`default_nettype wire

//--- source/fm_compressor.sv
// FM sample attenuator followed by a two-slope compressor, two cycles deep
`timescale 1ns/10ps
`default_nettype none

module fm_compressor #(
	parameter int COMP_F = audio_pkg::COMP_F_DEF,
	parameter int COMP_A = audio_pkg::COMP_A_DEF
) (
	input  wire                                   clk_sys,
	input  wire                                   RESET,
	input  wire signed [audio_pkg::SAMPLE_W-1:0]  fm_sample_i,
	output logic signed [audio_pkg::SAMPLE_W-1:0] fm_comp_o
);

	localparam int SW      = audio_pkg::SAMPLE_W;
	localparam int FULL    = (2 ** (SW - 1)) - 1;
	// Knee is rounded up so the top of the curve never wraps
	localparam int KNEE    = ((FULL * (COMP_F - 1)) / ((COMP_F * COMP_A) - 1)) + 1;
	localparam int OFFSET  = KNEE * COMP_A;

	logic signed [SW-1:0] att_q;
	logic                 att_neg;
	logic [SW-1:0]        att_mag;
	logic [31:0]          comp_mag;
	logic signed [SW-1:0] comp_val;

	// Stage 1 takes one eighth off the raw sample
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			att_q <= '0;
		end else begin
			att_q <= fm_sample_i - (fm_sample_i >>> 3);
		end
	end

	// ==================================================
	// Two-slope curve on the magnitude
	// ==================================================

	always_comb begin
		att_neg = att_q[SW-1];
		att_mag = att_neg ? -att_q : att_q;
		if (int'(att_mag) < KNEE) begin
			comp_mag = att_mag * COMP_A;
		end else begin
			// Gentle slope above the knee
			comp_mag = ((att_mag - KNEE) / COMP_F) + OFFSET;
		end
		comp_val = att_neg ? -comp_mag[SW-1:0] : comp_mag[SW-1:0];
	end

	// Stage 2 holds the compressed sample
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			fm_comp_o <= '0;
		end else begin
			fm_comp_o <= comp_val;
		end
	end

endmodule

`default_nettype wire

//--- source/digimax_dac.sv
// DigiMax four-channel DAC bank with req/ack write port and channel mode guess
`timescale 1ns/10ps
`default_nettype none

module digimax_dac (
	input  wire                              clk_sys,
	input  wire                              RESET,
	input  wire                              dmx_en_i,
	input  wire                              wr_req_i,
	input  wire [digimax_pkg::ADDR_W-1:0]    wr_addr_i,
	input  wire [digimax_pkg::DAC_W-1:0]     wr_data_i,
	output logic                             wr_ack_o,
	output logic [digimax_pkg::SUM_W-1:0]    dac_l_o,
	output logic [digimax_pkg::SUM_W-1:0]    dac_r_o
);

	localparam int CH_W = $clog2(digimax_pkg::NUM_CH);

	logic [digimax_pkg::DAC_W-1:0]  dac_q [digimax_pkg::NUM_CH];
	logic [digimax_pkg::NUM_CH-1:0] act_q;
	logic                           wr_commit;
	logic                           wr_in_range;
	logic [CH_W-1:0]                wr_ch;

	// Adds two channels without losing the carry
	function automatic logic [digimax_pkg::SUM_W-1:0] side_sum(
		input logic [digimax_pkg::DAC_W-1:0] a,
		input logic [digimax_pkg::DAC_W-1:0] b
	);
		side_sum = {1'b0, a} + {1'b0, b};
	endfunction

	// ==================================================
	// Four-phase write handshake
	// ==================================================

	// A write lands only on the first cycle of a new request
	assign wr_commit   = wr_req_i & ~wr_ack_o;
	assign wr_in_range = ~wr_addr_i[digimax_pkg::ADDR_W-1];
	assign wr_ch       = wr_addr_i[CH_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_ack_o <= 1'b0;
		end else if (wr_commit) begin
			wr_ack_o <= 1'b1;
		end else if (!wr_req_i) begin
			// Host has let go of req
			wr_ack_o <= 1'b0;
		end
	end

	// ==================================================
	// Channel registers and activity flags
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET || !dmx_en_i) begin
			for (int i = 0; i < digimax_pkg::NUM_CH; i++) begin
				dac_q[i] <= '0;
			end
			act_q <= '0;
		end else if (wr_commit && wr_in_range) begin
			dac_q[wr_ch] <= wr_data_i;
			// Only a nonzero value marks the channel as in use
			if (wr_data_i != '0) begin
				act_q[wr_ch] <= 1'b1;
			end
		end
	end

	// ==================================================
	// Mono, stereo or four-channel guess
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET || !dmx_en_i) begin
			dac_l_o <= '0;
			dac_r_o <= '0;
		end else if (act_q < 2) begin
			// Mono, channel 0 on both sides
			dac_l_o <= side_sum(dac_q[0], dac_q[0]);
			dac_r_o <= side_sum(dac_q[0], dac_q[0]);
		end else if (act_q == 2) begin
			// Stereo pair on channels 0 and 1
			dac_l_o <= side_sum(dac_q[1], dac_q[1]);
			dac_r_o <= side_sum(dac_q[0], dac_q[0]);
		end else begin
			dac_l_o <= side_sum(dac_q[1], dac_q[2]);
			dac_r_o <= side_sum(dac_q[0], dac_q[3]);
		end
	end

endmodule

`default_nettype wire

//--- source/digimax_pkg.sv
// DigiMax register map with channel count, address fields and data widths
`default_nettype none

package digimax_pkg;

	// Number of DAC channels in the bank
	localparam int NUM_CH = 4;

	// One channel register
	localparam int DAC_W = 8;

	// Write address; top bit flags an address outside the DAC
	// and the low bits pick the channel
	localparam int ADDR_W = 3;

	// Sum of two channels for one side
	localparam int SUM_W = 9;

	// Where a side sum lands in the mix word
	localparam int DAC_SHIFT = 6;

endpackage

`default_nettype wire

//--- source/audio_pkg.sv
// Audio datapath constants for sample widths, compressor defaults and click level
`default_nettype none

package audio_pkg;

	// ==================================================
	// Sample widths
	// ==================================================

	// FM sample and final mixed sample, signed
	localparam int SAMPLE_W = 16;

	// SID voice output, signed and wider than the mix
	localparam int SID_W = 18;

	// ==================================================
	// Compressor defaults
	// ==================================================

	// Divisor applied to the part of the magnitude above the knee
	localparam int COMP_F_DEF = 4;

	// Gain applied below the knee
	localparam int COMP_A_DEF = 2;

	// ==================================================
	// Cassette click
	// ==================================================

	// Position of the click bit inside the mix word
	localparam int CASS_SHIFT = 10;

endpackage

`default_nettype wire
